//--- Makefile
TOP = tb_adc

.PHONY: all build lint clean

all: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f compile.f

lint:
	verilator --lint-only --timing --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir

//--- adc.sv
`timescale 1ns/1ps

module adc
    import adc_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    fs_init,
    input  logic                    fs_type,
    input  logic                    fs_conf,
    input  logic                    fs_conv,
    output logic                    fd_init,
    output logic                    fd_type,
    output logic                    fd_conf,
    output logic                    fd_conv,
    input  logic [31:0]             data_cmd,
    output stat_word_t              data_stat,
    input  logic [NUM_CHIPS-1:0]    spi_miso,
    output logic [NUM_CHIPS-1:0]    spi_mosi,
    output logic [NUM_CHIPS-1:0]    spi_sclk,
    output logic [NUM_CHIPS-1:0]    spi_cs,
    input  logic [NUM_CHIPS-1:0]    fifo_rxen,
    output logic [16*NUM_CHIPS-1:0] fifo_rxd
);

    cmd_cfg_t                   cfg;
    logic [NUM_CHIPS-1:0]       dn_init, dn_type, dn_conf, dn_conv;
    logic [NUM_CHIPS-1:0][15:0] temps, samples;
    logic [2*NUM_CHIPS-1:0]     types;
    logic [NUM_CHIPS-1:0]       ok, push;

    cmd_decode decode_i (
        .clk(clk), .arst_n(arst_n), .fs_conf(fs_conf), .data_cmd(data_cmd), .cfg(cfg)
    );

    for (genvar i = 0; i < NUM_CHIPS; i++) begin : g_chip
        intan chip_i (
            .clk(clk), .arst_n(arst_n),
            .fs_init(fs_init), .fs_type(fs_type), .fs_conf(fs_conf), .fs_conv(fs_conv),
            .cfg(cfg),
            .fd_init(dn_init[i]), .fd_type(dn_type[i]),
            .fd_conf(dn_conf[i]), .fd_conv(dn_conv[i]),
            .chip_temp(temps[i]), .chip_type(types[2*i +: 2]), .chip_ok(ok[i]),
            .sample(samples[i]), .sample_push(push[i]),
            .spi_miso(spi_miso[i]), .spi_mosi(spi_mosi[i]),
            .spi_sclk(spi_sclk[i]), .spi_cs(spi_cs[i])
        );

        sample_fifo fifo_i (
            .clk(clk), .arst_n(arst_n),
            .push(push[i]), .push_data(samples[i]),
            .pop(fifo_rxen[i]), .head(fifo_rxd[16*i +: 16])
        );
    end

    stat_merge merge_i (
        .clk(clk), .arst_n(arst_n),
        .done_init(dn_init), .done_type(dn_type), .done_conf(dn_conf), .done_conv(dn_conv),
        .chip_temps(temps), .chip_types(types), .chip_ok(ok),
        .fd_init(fd_init), .fd_type(fd_type), .fd_conf(fd_conf), .fd_conv(fd_conv),
        .data_stat(data_stat)
    );

    a_strobe_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({fs_init, fs_type, fs_conf, fs_conv}))
        else $error("More than one host strobe in one cycle.");

endmodule

//--- adc_pkg.sv
package adc_pkg;

    localparam int NUM_CHIPS  = 4;
    localparam int NUM_CH     = 4;                   // Channels per conv sequence.
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // Fields taken from data_cmd[23:12] on fs_conf.
    typedef struct packed {
        logic [3:0] freq_samp;                       // data_cmd[23:20].
        logic [3:0] filt_up;                         // data_cmd[19:16].
        logic [3:0] filt_low;                        // data_cmd[15:12].
    } cmd_cfg_t;

    // Host status word.
    typedef struct packed {
        logic [15:0] device_temp;                    // Average of the chip temperatures.
        logic [7:0]  device_type;                    // Chip 3 in the top pair.
        logic [3:0]  device_stat;                    // One health bit per chip.
        logic [3:0]  rsvd;
    } stat_word_t;

endpackage

//--- cmd_decode.sv
`timescale 1ns/1ps

module cmd_decode
    import adc_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        fs_conf,
    input  logic [31:0] data_cmd,
    output cmd_cfg_t    cfg
);

    // Held until the next fs_conf so a running sequence keeps its codes.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg <= '0;
        end else if (fs_conf) begin
            cfg.freq_samp <= data_cmd[23:20];
            cfg.filt_up   <= data_cmd[19:16];
            cfg.filt_low  <= data_cmd[15:12];
        end
    end

endmodule

//--- compile.f
adc_pkg.sv
intan_pkg.sv
cmd_decode.sv
intan_spi.sv
intan.sv
sample_fifo.sv
stat_merge.sv
adc.sv
intan_model.sv
tb_adc.sv

//--- intan.sv
`timescale 1ns/1ps

module intan
    import adc_pkg::*, intan_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        fs_init,
    input  logic        fs_type,
    input  logic        fs_conf,
    input  logic        fs_conv,
    input  cmd_cfg_t    cfg,
    output logic        fd_init,
    output logic        fd_type,
    output logic        fd_conf,
    output logic        fd_conv,
    output logic [15:0] chip_temp,
    output logic [1:0]  chip_type,
    output logic        chip_ok,
    output logic [15:0] sample,
    output logic        sample_push,
    input  logic        spi_miso,
    output logic        spi_mosi,
    output logic        spi_sclk,
    output logic        spi_cs
);

    logic [1:0]  state, seq, cfg_k;
    logic [3:0]  idx, nwords;
    logic [3:0]  fd_vec;
    logic [2:0]  cur_tag, tag_p1, tag_p2;
    logic [7:0]  cur_exp, exp_p1, exp_p2;
    logic [15:0] rx_word;
    logic [2:0]  push_cnt;
    logic        strobe, go, last, start, busy, done, id_ok, rb_bad;
    spi_cmd_u    cmd;

    assign strobe = fs_init | fs_type | fs_conf | fs_conv;
    assign go     = strobe && (state == ST_IDLE);
    assign last   = (state == ST_GAP) && (idx == nwords);
    assign start  = (state == ST_XFER) && !busy && !done;  // After one idle cycle in ST_GAP.
    assign {fd_conv, fd_conf, fd_type, fd_init} = fd_vec;

    always_comb begin
        case (seq)
            SEQ_INIT: nwords = 4'(2 + DUMMY_WORDS);
            SEQ_TYPE: nwords = 4'(1 + DUMMY_WORDS);
            SEQ_CONF: nwords = 4'(6 + DUMMY_WORDS);
            default:  nwords = 4'(NUM_CH + DUMMY_WORDS);
        endcase
    end

    // Command word and the tag of the result it will return.
    always_comb begin
        cmd     = '0;
        cur_tag = TAG_NONE;
        cur_exp = '0;
        cfg_k   = (idx < 4'd3) ? idx[1:0] : 2'(idx - 4'd3);
        if (idx >= nwords - 4'(DUMMY_WORDS)) begin
            cmd.regs.op   = OP_READ;                 // Dummy word.
            cmd.regs.addr = REG_ID;
        end else begin
            case (seq)
                SEQ_INIT: begin
                    cmd.conv.op = (idx == 4'd0) ? OP_CALIBRATE : OP_CONVERT;
                    if (idx != 4'd0) begin
                        cmd.conv.ch = TEMP_CH;
                        cur_tag     = TAG_TEMP;
                    end
                end
                SEQ_TYPE: begin
                    cmd.regs.op   = OP_READ;
                    cmd.regs.addr = REG_ID;
                    cur_tag       = TAG_TYPE;
                end
                SEQ_CONF: begin
                    case (cfg_k)
                        2'd0:    cur_exp = {4'h0, cfg.freq_samp};
                        2'd1:    cur_exp = {4'h0, cfg.filt_up};
                        default: cur_exp = {4'h0, cfg.filt_low};
                    endcase
                    cmd.regs.addr = (cfg_k == 2'd0) ? REG_FS :
                                    (cfg_k == 2'd1) ? REG_FILT_UP : REG_FILT_LOW;
                    if (idx < 4'd3) begin
                        cmd.regs.op   = OP_WRITE;
                        cmd.regs.data = cur_exp;
                    end else begin
                        cmd.regs.op = OP_READ;
                        cur_tag     = TAG_CHECK;
                    end
                end
                default: begin
                    cmd.conv.op = OP_CONVERT;
                    cmd.conv.ch = 6'(idx);
                    cur_tag     = TAG_SAMPLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= ST_IDLE;
            seq    <= SEQ_INIT;
            idx    <= '0;
            fd_vec <= '0;
            tag_p1 <= TAG_NONE;
            tag_p2 <= TAG_NONE;
            exp_p1 <= '0;
            exp_p2 <= '0;
        end else begin
            if (strobe) fd_vec <= '0;
            case (state)
                ST_IDLE: if (go) begin
                    state  <= ST_GAP;
                    idx    <= '0;
                    seq    <= fs_type ? SEQ_TYPE : fs_conf ? SEQ_CONF :
                              fs_conv ? SEQ_CONV : SEQ_INIT;
                    tag_p1 <= TAG_NONE;
                    tag_p2 <= TAG_NONE;
                end
                ST_GAP: begin
                    state <= last ? ST_IDLE : ST_XFER;
                    if (last) fd_vec[seq] <= 1'b1;
                end
                default: if (done) begin
                    state  <= ST_GAP;
                    idx    <= idx + 4'd1;
                    tag_p2 <= tag_p1;
                    tag_p1 <= cur_tag;
                    exp_p2 <= exp_p1;
                    exp_p1 <= cur_exp;
                end
            endcase
        end
    end

    // Route the word returned for the command sent two words earlier.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            chip_temp   <= '0;
            chip_type   <= '0;
            chip_ok     <= 1'b0;
            id_ok       <= 1'b0;
            rb_bad      <= 1'b0;
            sample_push <= 1'b0;
            push_cnt    <= '0;
        end else begin
            sample_push <= 1'b0;
            if (fs_type) begin
                id_ok   <= 1'b0;
                chip_ok <= 1'b0;
            end
            if (go && fs_conf) rb_bad <= 1'b0;
            if (go && fs_conv) push_cnt <= '0;
            if (done) begin
                case (tag_p2)
                    TAG_TEMP:  chip_temp <= rx_word;
                    TAG_TYPE: begin
                        chip_type <= rx_word[1:0];
                        id_ok     <= |(rx_word[7:0] & ID_VALID);
                    end
                    TAG_CHECK: if (rx_word[7:0] != exp_p2) rb_bad <= 1'b1;
                    TAG_SAMPLE: begin
                        sample_push <= 1'b1;
                        push_cnt    <= push_cnt + 3'd1;
                    end
                    default: ;
                endcase
            end
            if (last && seq == SEQ_CONF) chip_ok <= id_ok & ~rb_bad;
        end
    end

    always_ff @(posedge clk) begin
        if (done && tag_p2 == TAG_SAMPLE) sample <= rx_word;
    end

    intan_spi spi_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (start),
        .tx_word  (cmd),
        .rx_word  (rx_word),
        .busy     (busy),
        .done     (done),
        .spi_miso (spi_miso),
        .spi_mosi (spi_mosi),
        .spi_sclk (spi_sclk),
        .spi_cs   (spi_cs)
    );

    a_push_conv: assert property (@(posedge clk) disable iff (!arst_n)
        sample_push |-> (seq == SEQ_CONV) && (state != ST_IDLE))
        else $error("sample_push outside a conv sequence.");

    a_push_max: assert property (@(posedge clk) disable iff (!arst_n)
        push_cnt <= 3'(NUM_CH))
        else $error("Too many samples in one conv sequence.");

endmodule

//--- intan_model.sv
`timescale 1ns/1ps

module intan_model
    import adc_pkg::*, intan_pkg::*;
#(
    parameter int CHIP_IDX = 0
)
(
    input  logic     spi_cs,
    input  logic     spi_sclk,
    input  logic     spi_mosi,
    output logic     spi_miso,
    output cmd_cfg_t cfg_regs
);

    localparam int TEMP_BASE = 1000;
    localparam int TEMP_STEP = 4;
    localparam int CHIP_STEP = 4096;
    localparam int CH_STEP   = 16;

    logic [7:0]  regs [64];
    logic [15:0] rx_sh, tx_sh;
    logic [15:0] res, res_next, res_pend;
    logic [15:0] conv_cnt;
    spi_cmd_u    cmd;

    initial begin
        for (int a = 0; a < 64; a++) begin
            regs[a] = 8'h00;
        end
        regs[REG_ID] = 8'(CHIP_IDX + 1);
        rx_sh    = '0;
        tx_sh    = '0;
        res_next = '0;
        res_pend = '0;
        conv_cnt = '0;
        spi_miso = 1'b0;
        cfg_regs = '0;
        forever begin
            @(negedge spi_cs);
            tx_sh    = res_next;                     // Result of the word two back.
            spi_miso = tx_sh[15];
            for (int b = 0; b < 16; b++) begin
                @(posedge spi_sclk);
                rx_sh = {rx_sh[14:0], spi_mosi};
                @(negedge spi_sclk);
                tx_sh    = {tx_sh[14:0], 1'b0};
                spi_miso = (b < 15) ? tx_sh[15] : 1'b0;
            end
            cmd = rx_sh;
            res = '0;
            case (cmd.regs.op)
                OP_CONVERT: begin
                    if (cmd.conv.ch == TEMP_CH) begin
                        res = 16'(TEMP_BASE + TEMP_STEP * CHIP_IDX);
                    end else begin
                        res      = 16'(CHIP_IDX * CHIP_STEP + int'(cmd.conv.ch) * CH_STEP);
                        res      = res + conv_cnt;
                        conv_cnt = conv_cnt + 16'd1;
                    end
                end
                OP_WRITE: regs[cmd.regs.addr] = cmd.regs.data;
                OP_READ:  res = {8'h00, regs[cmd.regs.addr]};
                default:  res = '0;                  // Calibration returns nothing useful.
            endcase
            res_next = res_pend;
            res_pend = res;
            cfg_regs.freq_samp = regs[REG_FS][3:0];
            cfg_regs.filt_up   = regs[REG_FILT_UP][3:0];
            cfg_regs.filt_low  = regs[REG_FILT_LOW][3:0];
        end
    end

endmodule

//--- intan_pkg.sv
package intan_pkg;

    // Opcodes in the top two bits of a command word.
    localparam logic [1:0] OP_CONVERT   = 2'b00;
    localparam logic [1:0] OP_CALIBRATE = 2'b01;
    localparam logic [1:0] OP_WRITE     = 2'b10;
    localparam logic [1:0] OP_READ      = 2'b11;

    localparam logic [5:0] REG_FS       = 6'd5;
    localparam logic [5:0] REG_FILT_UP  = 6'd8;
    localparam logic [5:0] REG_FILT_LOW = 6'd12;
    localparam logic [5:0] REG_ID       = 6'd63;

    localparam logic [5:0] TEMP_CH   = 6'd48;        // Temperature sensor channel.
    localparam logic [7:0] ID_VALID  = 8'hff;
    localparam int         SCLK_HALF = 1;            // SPI clock half period in clk cycles.

    // Results come back two words late.
    localparam int DUMMY_WORDS = 2;

    // Sequence codes, also the bit index of the done levels.
    localparam logic [1:0] SEQ_INIT = 2'd0;
    localparam logic [1:0] SEQ_TYPE = 2'd1;
    localparam logic [1:0] SEQ_CONF = 2'd2;
    localparam logic [1:0] SEQ_CONV = 2'd3;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_GAP  = 2'd1;
    localparam logic [1:0] ST_XFER = 2'd2;

    // Destination of a returned word.
    localparam logic [2:0] TAG_NONE   = 3'd0;
    localparam logic [2:0] TAG_TEMP   = 3'd1;
    localparam logic [2:0] TAG_TYPE   = 3'd2;
    localparam logic [2:0] TAG_CHECK  = 3'd3;
    localparam logic [2:0] TAG_SAMPLE = 3'd4;

    typedef struct packed {
        logic [1:0] op;
        logic [5:0] ch;
        logic [7:0] rsvd;
    } conv_t;

    typedef struct packed {
        logic [1:0] op;
        logic [5:0] addr;
        logic [7:0] data;
    } reg_t;

    typedef union packed {
        conv_t conv;
        reg_t  regs;
    } spi_cmd_u;

endpackage

//--- intan_spi.sv
`timescale 1ns/1ps

module intan_spi
    import intan_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        start,
    input  logic [15:0] tx_word,
    output logic [15:0] rx_word,
    output logic        busy,
    output logic        done,
    input  logic        spi_miso,
    output logic        spi_mosi,
    output logic        spi_sclk,
    output logic        spi_cs
);

    logic [3:0]  hcnt;
    logic [3:0]  bit_cnt;
    logic [15:0] tx_sh;
    logic [15:0] rx_sh;
    logic        tick;

    assign tick    = busy && (hcnt == 4'(SCLK_HALF - 1));
    assign rx_word = rx_sh;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            hcnt     <= '0;
            bit_cnt  <= '0;
            spi_cs   <= 1'b1;
            spi_sclk <= 1'b0;
            spi_mosi <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                busy     <= 1'b1;
                spi_cs   <= 1'b0;
                spi_mosi <= tx_word[15];             // MSB first.
                bit_cnt  <= '0;
                hcnt     <= '0;
            end else if (busy) begin
                hcnt <= tick ? '0 : hcnt + 4'd1;
                if (tick) begin
                    spi_sclk <= ~spi_sclk;
                    if (spi_sclk) begin              // Falling edge.
                        if (bit_cnt == 4'd15) begin
                            busy     <= 1'b0;
                            done     <= 1'b1;
                            spi_cs   <= 1'b1;
                            spi_mosi <= 1'b0;
                        end else begin
                            bit_cnt  <= bit_cnt + 4'd1;
                            spi_mosi <= tx_sh[14];
                        end
                    end
                end
            end
        end
    end

    // Shift registers carry payload only.
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            tx_sh <= tx_word;
        end else if (tick && spi_sclk) begin
            tx_sh <= {tx_sh[14:0], 1'b0};
        end
        if (tick && !spi_sclk) begin
            rx_sh <= {rx_sh[14:0], spi_miso};        // Sampled on the rising edge.
        end
    end

    a_start_idle: assert property (@(posedge clk) disable iff (!arst_n) start |-> !busy)
        else $error("intan_spi start while busy.");

endmodule

//--- sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo
    import adc_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        push,
    input  logic [15:0] push_data,
    input  logic        pop,
    output logic [15:0] head
);

    logic [15:0]           mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr, rd_ptr;
    logic [FIFO_PTR_W:0]   count;
    logic                  do_push, do_pop;

    assign do_push = push && (count != (FIFO_PTR_W + 1)'(FIFO_DEPTH));  // Dropped when full.
    assign do_pop  = pop && (count != '0);
    assign head    = (count == '0) ? '0 : mem[rd_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + FIFO_PTR_W'(1);
            if (do_pop)  rd_ptr <= rd_ptr + FIFO_PTR_W'(1);
            count <= count + (FIFO_PTR_W + 1)'(do_push) - (FIFO_PTR_W + 1)'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        push |-> count != (FIFO_PTR_W + 1)'(FIFO_DEPTH))
        else $error("Sample pushed into a full FIFO.");

    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
        pop |-> count != '0)
        else $error("Pop from an empty FIFO.");

endmodule

//--- stat_merge.sv
`timescale 1ns/1ps

module stat_merge
    import adc_pkg::*;
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [NUM_CHIPS-1:0]      done_init,
    input  logic [NUM_CHIPS-1:0]      done_type,
    input  logic [NUM_CHIPS-1:0]      done_conf,
    input  logic [NUM_CHIPS-1:0]      done_conv,
    input  logic [NUM_CHIPS-1:0][15:0] chip_temps,
    input  logic [2*NUM_CHIPS-1:0]    chip_types,
    input  logic [NUM_CHIPS-1:0]      chip_ok,
    output logic                      fd_init,
    output logic                      fd_type,
    output logic                      fd_conf,
    output logic                      fd_conv,
    output stat_word_t                data_stat
);

    logic [17:0] temp_sum;

    always_comb begin
        temp_sum = '0;
        for (int i = 0; i < NUM_CHIPS; i++) begin
            temp_sum = temp_sum + 18'(chip_temps[i]);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            {fd_init, fd_type, fd_conf, fd_conv} <= '0;
            data_stat <= '0;
        end else begin
            fd_init <= &done_init;                   // All chips finished.
            fd_type <= &done_type;
            fd_conf <= &done_conf;
            fd_conv <= &done_conv;
            data_stat.device_temp <= temp_sum[17:2]; // Sum of four, divided by four.
            data_stat.device_type <= chip_types;
            data_stat.device_stat <= chip_ok;
            data_stat.rsvd        <= '0;
        end
    end

endmodule

//--- tb_adc.sv
`timescale 1ns/1ps

module tb_adc
    import adc_pkg::*, intan_pkg::*;
();

    // Idle cycle, start cycle, 32 SCLK half periods and the done cycle per word.
    localparam int WORD_CYC = 35;
    localparam int LAT_INIT = 4 * WORD_CYC + 2;
    localparam int LAT_TYPE = 3 * WORD_CYC + 2;
    localparam int LAT_CONF = 8 * WORD_CYC + 2;
    localparam int LAT_CONV = 6 * WORD_CYC + 2;
    localparam int WATCHDOG_CYCLES = 16 + (4 + 3 + 8 + 6 + 8 + 6) * WORD_CYC + 6 * 8 + 2 * 8
                                     + 500;

    logic                       clk, arst_n;
    logic                       fs_init, fs_type, fs_conf, fs_conv;
    logic                       fd_init, fd_type, fd_conf, fd_conv;
    logic [31:0]                data_cmd, cmd_word;
    stat_word_t                 data_stat;
    logic [NUM_CHIPS-1:0]       spi_miso, spi_mosi, spi_sclk, spi_cs, fifo_rxen;
    logic [16*NUM_CHIPS-1:0]    fifo_rxd;
    cmd_cfg_t                   model_cfg [NUM_CHIPS];
    cmd_cfg_t                   exp_cfg;
    logic [NUM_CHIPS-1:0][15:0] exp_head;
    logic [1:0]                 last_seq;
    logic                       empty_chk, any_fs;
    logic [3:0]                 fds;
    int                         since_strobe, conv_base;
    integer                     seed = 10157;

    assign any_fs = fs_init | fs_type | fs_conf | fs_conv;
    assign fds    = {fd_conv, fd_conf, fd_type, fd_init};

    adc dut_i (
        .clk(clk), .arst_n(arst_n),
        .fs_init(fs_init), .fs_type(fs_type), .fs_conf(fs_conf), .fs_conv(fs_conv),
        .fd_init(fd_init), .fd_type(fd_type), .fd_conf(fd_conf), .fd_conv(fd_conv),
        .data_cmd(data_cmd), .data_stat(data_stat),
        .spi_miso(spi_miso), .spi_mosi(spi_mosi), .spi_sclk(spi_sclk), .spi_cs(spi_cs),
        .fifo_rxen(fifo_rxen), .fifo_rxd(fifo_rxd)
    );

    for (genvar i = 0; i < NUM_CHIPS; i++) begin : g_model
        intan_model #(.CHIP_IDX(i)) model_i (
            .spi_cs(spi_cs[i]), .spi_sclk(spi_sclk[i]), .spi_mosi(spi_mosi[i]),
            .spi_miso(spi_miso[i]), .cfg_regs(model_cfg[i])
        );

        a_model_cfg: assert property (@(posedge clk) disable iff (!arst_n)
            $rose(fd_conf) |-> model_cfg[i] == exp_cfg)
            else report_fail($sformatf("CHECK FAILED model_cfg[%0d]: got 'h%0h expected 'h%0h",
                i, $sampled(model_cfg[i]), $sampled(exp_cfg)));

        a_fifo_head: assert property (@(posedge clk) disable iff (!arst_n)
            fifo_rxen[i] |-> fifo_rxd[16*i +: 16] == exp_head[i])
            else report_fail($sformatf("CHECK FAILED fifo_rxd[%0d]: got 'h%0h expected 'h%0h",
                i, $sampled(fifo_rxd[16*i +: 16]), $sampled(exp_head[i])));
    end

    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (any_fs) since_strobe <= 0;
        else if (since_strobe < 100000) since_strobe <= since_strobe + 1;
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    function automatic logic [15:0] sample_value(input int chip, input int ch, input int n);
        return 16'(chip * 4096 + ch * 16 + n);
    endfunction

    function automatic logic [15:0] expected_temp();
        int sum;
        sum = 0;
        for (int i = 0; i < NUM_CHIPS; i++) begin
            sum = sum + 1000 + 4 * i;
        end
        return 16'(sum >> 2);
    endfunction

    function automatic logic [7:0] expected_types();
        logic [7:0] t;
        for (int i = 0; i < NUM_CHIPS; i++) begin
            t[2*i +: 2] = 2'(i + 1);                 // Low bits of the ID register.
        end
        return t;
    endfunction

    function automatic logic done_of(input logic [1:0] seq);
        return fds[seq];
    endfunction

    a_reset_values: assert property (@(posedge clk) $rose(arst_n) |->
        fds == 4'h0 && data_stat == '0 && spi_cs == 4'hf && fifo_rxd == '0)
        else report_fail($sformatf("CHECK FAILED reset: fd 'h%0h data_stat 'h%0h spi_cs 'h%0h",
            $sampled(fds), $sampled(data_stat), $sampled(spi_cs)));

    a_reset_spi: assert property (@(posedge clk) $rose(arst_n) |->
        spi_sclk == 4'h0 && spi_mosi == 4'h0)
        else report_fail($sformatf("CHECK FAILED reset: spi_sclk 'h%0h spi_mosi 'h%0h",
            $sampled(spi_sclk), $sampled(spi_mosi)));

    a_init_lat: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(fd_init) |-> last_seq == SEQ_INIT && since_strobe == LAT_INIT)
        else report_fail($sformatf("CHECK FAILED fd_init: rose after 'h%0h expected 'h%0h",
            $sampled(since_strobe), LAT_INIT));

    a_type_lat: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(fd_type) |-> last_seq == SEQ_TYPE && since_strobe == LAT_TYPE)
        else report_fail($sformatf("CHECK FAILED fd_type: rose after 'h%0h expected 'h%0h",
            $sampled(since_strobe), LAT_TYPE));

    a_conf_lat: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(fd_conf) |-> last_seq == SEQ_CONF && since_strobe == LAT_CONF)
        else report_fail($sformatf("CHECK FAILED fd_conf: rose after 'h%0h expected 'h%0h",
            $sampled(since_strobe), LAT_CONF));

    a_conv_lat: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(fd_conv) |-> last_seq == SEQ_CONV && since_strobe == LAT_CONV)
        else report_fail($sformatf("CHECK FAILED fd_conv: rose after 'h%0h expected 'h%0h",
            $sampled(since_strobe), LAT_CONV));

    a_fd_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(fds))
        else report_fail("More than one done level was high at the same time.");

    a_fd_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !any_fs && !$past(any_fs) |=> (fds & $past(fds)) == $past(fds))
        else report_fail("A done level fell without a strobe.");

    a_temp: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(fd_init) |-> data_stat.device_temp == expected_temp())
        else report_fail($sformatf("CHECK FAILED device_temp: got 'h%0h expected 'h%0h",
            $sampled(data_stat.device_temp), expected_temp()));

    a_types: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(fd_conf) |-> data_stat.device_type == expected_types())
        else report_fail($sformatf("CHECK FAILED device_type: got 'h%0h expected 'h%0h",
            $sampled(data_stat.device_type), expected_types()));

    a_health: assert property (@(posedge clk) disable iff (!arst_n)
        ($rose(fd_conf) || $rose(fd_conv)) |-> data_stat.device_stat == 4'hf)
        else report_fail($sformatf("CHECK FAILED device_stat: got 'h%0h expected 'hf",
            $sampled(data_stat.device_stat)));

    a_fifo_empty: assert property (@(posedge clk) disable iff (!arst_n)
        empty_chk |-> fifo_rxd == '0)
        else report_fail($sformatf("CHECK FAILED fifo_rxd: got 'h%0h expected 'h0",
            $sampled(fifo_rxd)));

    task automatic run_seq(input logic [1:0] seq);
        @(posedge clk);
        case (seq)
            SEQ_INIT: fs_init <= 1'b1;
            SEQ_TYPE: fs_type <= 1'b1;
            SEQ_CONF: fs_conf <= 1'b1;
            default:  fs_conv <= 1'b1;
        endcase
        last_seq <= seq;
        @(posedge clk);
        {fs_init, fs_type, fs_conf, fs_conv} <= 4'h0;
        data_cmd <= ~data_cmd;                       // Only the strobe cycle may capture it.
        repeat (2) @(posedge clk);                   // Let the old done level clear.
        while (!done_of(seq)) @(posedge clk);
    endtask

    task automatic conf_random();
        @(posedge clk);
        cmd_word = $random(seed);
        if (cmd_word[23:12] == exp_cfg) cmd_word[23:12] = ~cmd_word[23:12];
        data_cmd <= cmd_word;
        exp_cfg  <= cmd_word[23:12];
        run_seq(SEQ_CONF);
    endtask

    task automatic drain_fifos();
        for (int k = 0; k < NUM_CH; k++) begin
            @(posedge clk);
            fifo_rxen <= '1;
            for (int i = 0; i < NUM_CHIPS; i++) begin
                exp_head[i] <= sample_value(i, k, conv_base + k);
            end
        end
        @(posedge clk);
        fifo_rxen <= '0;
        empty_chk <= 1'b1;
        @(posedge clk);
        empty_chk <= 1'b0;
        conv_base = conv_base + NUM_CH;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_fail("Watchdog expired before the test sequence finished.");
    end

    initial begin
        clk = 1'b0;
        arst_n = 1'b1;
        {fs_init, fs_type, fs_conf, fs_conv} = 4'h0;
        data_cmd = '0;
        fifo_rxen = '0;
        exp_cfg = '0;
        exp_head = '0;
        empty_chk = 1'b0;
        last_seq = SEQ_INIT;
        since_strobe = 0;
        conv_base = 0;
        #1 arst_n = 1'b0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) @(posedge clk);
        run_seq(SEQ_INIT);
        run_seq(SEQ_TYPE);
        conf_random();
        run_seq(SEQ_CONV);
        drain_fifos();
        conf_random();                               // New codes must reach every chip.
        run_seq(SEQ_CONV);
        drain_fifos();
        repeat (4) @(posedge clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule
